// File: Makefile
# Verilator build and run for the bundling accelerator testbench

VERILATOR ?= verilator
TOP       ?= tb_hdc_bundler
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/hdc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module hdc_checker import hdc_pkg::*; #(
    parameter int DIM = 512
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           read_start,
    input  logic           busy,
    input  logic           out_valid,
    input  stream_beat_t   out_beat,
    input  logic [DIM-1:0] exp_vec,
    output int             errors,
    output int             reads_done
);

    localparam int NWORDS = DIM / STREAM_W;
    // first beat is seen two edges after the start is sampled
    localparam int FIRST = 2;

    logic active;
    int   cyc;
    int   beats;

    // samples pre-edge values since DUT and stimulus both update on NBAs
    always @(posedge clk) begin
        int                  idx;
        int                  n_err;
        logic                win;
        logic                exp_busy;
        logic [STREAM_W-1:0] exp_data;
        if (rst) begin
            active = 1'b0;
            cyc = 0;
            beats = 0;
            errors <= 0;
            reads_done <= 0;
        end else begin
            n_err = 0;
            if (active) begin
                cyc = cyc + 1;
            end
            // busy from the cycle after the start through the last stream_v
            exp_busy = active && (cyc >= 1) && (cyc <= NWORDS);
            if (busy !== exp_busy) begin
                $display("CHECK FAILED busy read cycle %0d: got %h expected %h",
                         cyc, busy, exp_busy);
                n_err++;
            end
            // window where a beat must be on the output
            win = active && (cyc >= FIRST) && (cyc < FIRST + NWORDS);
            if (out_valid !== win) begin
                $display("ERROR: out_valid was %0b at the wrong time (read cycle %0d)",
                         out_valid, cyc);
                n_err++;
            end
            if (out_valid && win) begin
                idx = cyc - FIRST;
                exp_data = exp_vec[idx * STREAM_W +: STREAM_W];
                beats = beats + 1;
                if (out_beat.data !== exp_data) begin
                    $display("CHECK FAILED out_beat.data beat %0d: got %h expected %h",
                             idx, out_beat.data, exp_data);
                    n_err++;
                end
                if (out_beat.last !== (idx == NWORDS - 1)) begin
                    $display("CHECK FAILED out_beat.last beat %0d: got %h expected %h",
                             idx, out_beat.last, (idx == NWORDS - 1));
                    n_err++;
                end
            end
            // read over, beat count is final
            if (active && cyc == FIRST + NWORDS) begin
                if (beats != NWORDS) begin
                    $display("ERROR: read gave %0d beats instead of %0d", beats, NWORDS);
                    n_err++;
                end
                active = 1'b0;
                reads_done <= reads_done + 1;
            end
            // outside a read the sequencer is idle and takes the start
            if (!active && read_start) begin
                active = 1'b1;
                cyc = 0;
                beats = 0;
            end
            errors <= errors + n_err;
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_hdc_bundler.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hdc_bundler import hdc_pkg::*; ();

    localparam int DIM = 512;
    localparam int NCORE = 8;
    localparam int CNT_W = 6;
    localparam int NWORDS = DIM / STREAM_W;
    localparam int CNT_MAX = 2 ** (CNT_W - 1) - 1;
    localparam int RESET_CYC = 4;
    localparam int N_ACC = 40;
    localparam int N_MASK = 12;
    localparam int N_SAT = 50;
    // start, walk, restart and drain of one read
    localparam int READ_CYC = NWORDS + 12;
    // stores, five reads, about a dozen config accesses, then slack
    localparam int MAX_CYCLES = RESET_CYC + 1 + N_ACC + N_MASK + N_SAT + 2
                              + 5 * READ_CYC + 12 * 3 + 100;

    logic                        clk = 1'b0;
    logic                        rst;
    logic [NCORE-1:0][DIM-1:0]   core_result;
    logic [NCORE-1:0]            store;
    cfg_bus_t                    cfg;
    logic                        read_start;
    logic [CFG_DATA_W-1:0]       cfg_rdata;
    logic                        busy;
    logic                        out_valid;
    stream_beat_t                out_beat;
    logic [DIM-1:0]              exp_vec;
    int                          chk_errors;
    int                          reads_done;

    // reference state
    int               model_cnt [DIM];
    logic [NCORE-1:0] model_mask;
    int               model_count;
    logic [DIM-1:0]   model_vec;

    int tb_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycles = 0;
    int seed = 32'h2ebcd731;

    hdc_bundler_top #(
        .DIM   (DIM),
        .NCORE (NCORE),
        .CNT_W (CNT_W)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .core_result (core_result),
        .store       (store),
        .cfg         (cfg),
        .read_start  (read_start),
        .cfg_rdata   (cfg_rdata),
        .busy        (busy),
        .out_valid   (out_valid),
        .out_beat    (out_beat)
    );

    hdc_checker #(
        .DIM (DIM)
    ) u_chk (
        .clk        (clk),
        .rst        (rst),
        .read_start (read_start),
        .busy       (busy),
        .out_valid  (out_valid),
        .out_beat   (out_beat),
        .exp_vec    (exp_vec),
        .errors     (chk_errors),
        .reads_done (reads_done)
    );

    always #10 clk = ~clk;

    // hard stop if a read never completes
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("ERROR: timeout, run went past %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // one cycle of the counters: clear, or masked votes with clamping
    function automatic logic [DIM-1:0] model_update(
        input logic [NCORE-1:0][DIM-1:0] vec,
        input logic [NCORE-1:0]          st,
        input logic                      clr
    );
        logic [DIM-1:0] signs;
        int             sum;
        for (int j = 0; j < DIM; j++) begin
            if (clr) begin
                model_cnt[j] = 0;
            end else begin
                sum = model_cnt[j];
                for (int k = 0; k < NCORE; k++) begin
                    if (st[k] && model_mask[k]) begin
                        sum = sum + (vec[k][j] ? 1 : -1);
                    end
                end
                if (sum > CNT_MAX) begin
                    sum = CNT_MAX;
                end else if (sum < -CNT_MAX) begin
                    sum = -CNT_MAX;
                end
                model_cnt[j] = sum;
            end
            // zero tie gives 0
            signs[j] = (model_cnt[j] > 0);
        end
        if (clr) begin
            model_count = 0;
        end else if (|(st & model_mask)) begin
            model_count++;
        end
        return signs;
    endfunction

    task automatic rand_vectors(output logic [NCORE-1:0][DIM-1:0] vec);
        for (int k = 0; k < NCORE; k++) begin
            for (int w = 0; w < DIM / 32; w++) begin
                vec[k][w * 32 +: 32] = $random(seed);
            end
        end
    endtask

    task automatic apply_store(input logic [NCORE-1:0][DIM-1:0] vec,
                               input logic [NCORE-1:0] st);
        @(posedge clk);
        core_result <= vec;
        store <= st;
        model_vec = model_update(vec, st, 1'b0);
    endtask

    task automatic end_stores();
        @(posedge clk);
        store <= '0;
    endtask

    // mask and clear act at the edge that samples the write
    task automatic write_cfg(input cfg_addr_e addr, input logic [CFG_DATA_W-1:0] data);
        @(posedge clk);
        cfg <= '{we: 1'b1, addr: addr, wdata: data};
        if (addr == ADDR_MASK) begin
            model_mask = data[NCORE-1:0];
        end else if (addr == ADDR_CLEAR) begin
            model_vec = model_update('0, '0, 1'b1);
        end
        @(posedge clk);
        cfg.we <= 1'b0;
    endtask

    task automatic check_count(input int expected);
        @(posedge clk);
        cfg <= '{we: 1'b0, addr: ADDR_COUNT, wdata: '0};
        @(negedge clk);
        if (cfg_rdata !== CFG_DATA_W'(expected)) begin
            $display("CHECK FAILED cfg_rdata: got %h expected %h",
                     cfg_rdata, CFG_DATA_W'(expected));
            tb_errors++;
        end
    endtask

    // optional second start lands while busy and must be dropped
    task automatic run_read(input logic restart);
        int r0;
        exp_vec = model_vec;
        r0 = reads_done;
        @(posedge clk);
        read_start <= 1'b1;
        @(posedge clk);
        read_start <= 1'b0;
        if (restart) begin
            @(posedge clk);
            read_start <= 1'b1;
            @(posedge clk);
            read_start <= 1'b0;
        end
        while (reads_done == r0) begin
            @(posedge clk);
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        int n;
        n = chk_errors + tb_errors - err_before;
        tests_run++;
        if (n != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d errors", tests_run, name, (n == 0) ? "ok" : "bad", n);
    endtask

    initial begin
        logic [NCORE-1:0][DIM-1:0] vec;
        int                        e0;
        rst = 1'b1;
        core_result = '0;
        store = '0;
        cfg = '0;
        read_start = 1'b0;
        exp_vec = '0;
        model_mask = '1;
        model_vec = model_update('0, '0, 1'b1);
        repeat (RESET_CYC) @(posedge clk);
        rst <= 1'b0;

        e0 = chk_errors + tb_errors;
        rand_vectors(vec);
        apply_store(vec, '1);
        end_stores();
        run_read(1'b0);
        finish_test("single store", e0);

        e0 = chk_errors + tb_errors;
        for (int i = 0; i < N_ACC; i++) begin
            rand_vectors(vec);
            apply_store(vec, NCORE'($random(seed)));
        end
        end_stores();
        run_read(1'b0);
        finish_test("accumulation", e0);

        // upper half of the cores switched off
        e0 = chk_errors + tb_errors;
        write_cfg(ADDR_CLEAR, '0);
        write_cfg(ADDR_MASK, 32'h0000_000f);
        for (int i = 0; i < N_MASK; i++) begin
            rand_vectors(vec);
            apply_store(vec, NCORE'($random(seed)));
        end
        end_stores();
        check_count(model_count);
        run_read(1'b0);
        finish_test("core mask", e0);

        // counters pinned at max, one all-zero vote pulls them down by NCORE
        e0 = chk_errors + tb_errors;
        write_cfg(ADDR_MASK, '1);
        write_cfg(ADDR_CLEAR, '0);
        for (int i = 0; i < N_SAT; i++) begin
            apply_store('1, '1);
        end
        apply_store('0, '1);
        end_stores();
        run_read(1'b0);
        finish_test("saturation", e0);

        e0 = chk_errors + tb_errors;
        write_cfg(ADDR_CLEAR, '0);
        check_count(0);
        run_read(1'b1);
        // stray beats from a wrongly taken restart show up here
        repeat (NWORDS + 4) @(posedge clk);
        finish_test("clear and restart", e0);

        $display("tests %0d, failed %0d, errors %0d",
                 tests_run, tests_failed, chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
rtl/hdc_pkg.sv
rtl/bundle_counter.sv
rtl/buffer_ctrl.sv
rtl/bundle_cfg_regs.sv
rtl/stream_sequencer.sv
rtl/hdc_bundler_top.sv
dv/hdc_checker.sv
dv/tb_hdc_bundler.sv

// File: rtl/buffer_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module buffer_ctrl import hdc_pkg::*; #(
    parameter int DIM   = 512,
    parameter int NCORE = 8,
    parameter int CNT_W = 12
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                clear,
    input  logic [NCORE-1:0][DIM-1:0]           core_result,
    input  logic [NCORE-1:0]                    store,
    input  logic [NCORE-1:0]                    core_mask,
    input  logic                                stream_v,
    input  logic [((DIM / STREAM_W) > 1 ? $clog2(DIM / STREAM_W) : 1)-1:0] stream_i,
    input  logic                                stream_last,
    output logic                                store_accept,
    output stream_beat_t                        out_beat
);

    // beats per hypervector
    localparam int NWORDS = DIM / STREAM_W;

    logic [NCORE-1:0] contrib;
    logic [DIM-1:0]   sign_vec;

    // only enabled cores vote
    assign contrib      = store & core_mask;
    assign store_accept = |contrib;

    // one counter per dimension
    for (genvar j = 0; j < DIM; j++) begin : g_dim
        logic [NCORE-1:0] dim_bits;

        // bit j from every core, core k in position k
        always_comb begin
            for (int k = 0; k < NCORE; k++) begin
                dim_bits[k] = core_result[k][j];
            end
        end

        bundle_counter #(
            .CNT_W (CNT_W),
            .NCORE (NCORE)
        ) u_cnt (
            .clk      (clk),
            .rst      (rst),
            .clear    (clear),
            .contrib  (contrib),
            .bits     (dim_bits),
            .sign_bit (sign_vec[j])
        );
    end

    // capture beat stream_i while the sequencer walks
    // sign bits are live, data lands one cycle after stream_v
    always_ff @(posedge clk) begin
        if (stream_v) begin
            out_beat.data <= sign_vec[stream_i * STREAM_W +: STREAM_W];
            out_beat.last <= stream_last;
        end
    end

    // index from the sequencer stays inside the vector
    a_index_in_range: assert property (
        @(posedge clk) disable iff (rst)
        stream_v |-> (int'(stream_i) < NWORDS)
    ) else $error("buffer_ctrl: stream_i out of range");

endmodule

`default_nettype wire

// File: rtl/bundle_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module bundle_cfg_regs import hdc_pkg::*; #(
    parameter int NCORE = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  cfg_bus_t              cfg,
    input  logic                  store_accept,
    output logic [CFG_DATA_W-1:0] cfg_rdata,
    output logic [NCORE-1:0]      core_mask,
    output logic                  clear
);

    logic                  clear_wr;
    logic                  clear_wr_q;
    logic [CFG_DATA_W-1:0] store_cnt;

    // write to the clear address this cycle
    assign clear_wr = cfg.we && (cfg.addr == ADDR_CLEAR);

    // rising edge of clear_wr, so a held write gives one pulse
    // acts on the counters at the same edge as the write
    assign clear = clear_wr && !clear_wr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            clear_wr_q <= 1'b0;
        end else begin
            clear_wr_q <= clear_wr;
        end
    end

    // enable mask, all cores on after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            core_mask <= '1;
        end else if (cfg.we && (cfg.addr == ADDR_MASK)) begin
            core_mask <= cfg.wdata[NCORE-1:0];
        end
    end

    // accepted store events
    // clear first, same priority as the counters
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            store_cnt <= '0;
        end else if (store_accept) begin
            store_cnt <= store_cnt + 1'b1;
        end
    end

    // combinational readback
    always_comb begin
        case (cfg.addr)
            ADDR_MASK:  cfg_rdata = CFG_DATA_W'(core_mask);
            ADDR_COUNT: cfg_rdata = store_cnt;
            default:    cfg_rdata = '0;
        endcase
    end

    // clear is a single-cycle pulse
    a_clear_pulse: assert property (
        @(posedge clk) disable iff (rst)
        clear |=> !clear
    ) else $error("bundle_cfg_regs: clear held for two cycles");

endmodule

`default_nettype wire

// File: rtl/bundle_counter.sv
`timescale 1ns/1ps
`default_nettype none

module bundle_counter #(
    parameter int CNT_W = 12,
    parameter int NCORE = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             clear,
    input  logic [NCORE-1:0] contrib,
    input  logic [NCORE-1:0] bits,
    output logic             sign_bit
);

    // ones count up to NCORE
    localparam int ONES_W = $clog2(NCORE + 1);
    // signed vote sum, -NCORE .. +NCORE
    localparam int SUM_W = ONES_W + 1;
    // headroom so cnt + vote never wraps
    localparam int EXT_W = ((CNT_W > SUM_W) ? CNT_W : SUM_W) + 1;

    // saturation limits, symmetric around zero
    localparam logic signed [EXT_W-1:0] CNT_MAX =
        {{(EXT_W - CNT_W + 1){1'b0}}, {(CNT_W - 1){1'b1}}};
    localparam logic signed [EXT_W-1:0] CNT_MIN = -CNT_MAX;

    logic signed [CNT_W-1:0] cnt;
    logic signed [CNT_W-1:0] cnt_next;
    logic signed [EXT_W-1:0] sum_ext;
    logic signed [SUM_W-1:0] vote;
    logic [ONES_W-1:0]       pos_cnt;
    logic [ONES_W-1:0]       neg_cnt;

    // count +1 and -1 voters among contributing cores
    always_comb begin
        pos_cnt = '0;
        neg_cnt = '0;
        for (int k = 0; k < NCORE; k++) begin
            if (contrib[k]) begin
                if (bits[k]) begin
                    pos_cnt = pos_cnt + 1'b1;
                end else begin
                    neg_cnt = neg_cnt + 1'b1;
                end
            end
        end
    end

    // net vote of this cycle
    assign vote = $signed({1'b0, pos_cnt}) - $signed({1'b0, neg_cnt});

    // add and clamp
    always_comb begin
        sum_ext = EXT_W'(cnt) + EXT_W'(vote);
        if (sum_ext > CNT_MAX) begin
            cnt_next = CNT_MAX[CNT_W-1:0];
        end else if (sum_ext < CNT_MIN) begin
            cnt_next = CNT_MIN[CNT_W-1:0];
        end else begin
            cnt_next = sum_ext[CNT_W-1:0];
        end
    end

    // clear wins over a store in the same cycle
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            cnt <= '0;
        end else begin
            cnt <= cnt_next;
        end
    end

    // strictly positive only, zero tie reads as 0
    assign sign_bit = (cnt > 0);

    // most negative code is never reachable
    a_cnt_in_range: assert property (
        @(posedge clk) disable iff (rst)
        (EXT_W'(cnt) >= CNT_MIN) && (EXT_W'(cnt) <= CNT_MAX)
    ) else $error("bundle_counter: counter left saturation range");

endmodule

`default_nettype wire

// File: rtl/hdc_bundler_top.sv
`timescale 1ns/1ps
`default_nettype none

module hdc_bundler_top import hdc_pkg::*; #(
    parameter int DIM   = 512,
    parameter int NCORE = 8,
    parameter int CNT_W = 12
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [NCORE-1:0][DIM-1:0]   core_result,
    input  logic [NCORE-1:0]            store,
    input  cfg_bus_t                    cfg,
    input  logic                        read_start,
    output logic [CFG_DATA_W-1:0]       cfg_rdata,
    output logic                        busy,
    output logic                        out_valid,
    output stream_beat_t                out_beat
);

    localparam int NWORDS = DIM / STREAM_W;
    localparam int IDX_W  = (NWORDS > 1) ? $clog2(NWORDS) : 1;

    logic [NCORE-1:0] core_mask;
    logic             clear;
    logic             store_accept;
    logic             stream_v;
    logic [IDX_W-1:0] stream_i;
    logic             stream_last;

    // mask, clear and store count
    bundle_cfg_regs #(
        .NCORE (NCORE)
    ) u_cfg (
        .clk          (clk),
        .rst          (rst),
        .cfg          (cfg),
        .store_accept (store_accept),
        .cfg_rdata    (cfg_rdata),
        .core_mask    (core_mask),
        .clear        (clear)
    );

    // counter array and beat register
    buffer_ctrl #(
        .DIM   (DIM),
        .NCORE (NCORE),
        .CNT_W (CNT_W)
    ) u_buf (
        .clk          (clk),
        .rst          (rst),
        .clear        (clear),
        .core_result  (core_result),
        .store        (store),
        .core_mask    (core_mask),
        .stream_v     (stream_v),
        .stream_i     (stream_i),
        .stream_last  (stream_last),
        .store_accept (store_accept),
        .out_beat     (out_beat)
    );

    // readout walk
    stream_sequencer #(
        .DIM (DIM)
    ) u_seq (
        .clk         (clk),
        .rst         (rst),
        .read_start  (read_start),
        .busy        (busy),
        .stream_v    (stream_v),
        .stream_i    (stream_i),
        .stream_last (stream_last),
        .out_valid   (out_valid)
    );

endmodule

`default_nettype wire

// File: rtl/hdc_pkg.sv
`default_nettype none

package hdc_pkg;

    // width of one readout beat
    localparam int STREAM_W = 128;

    // config bus data width
    localparam int CFG_DATA_W = 32;

    // config register map
    typedef enum logic [1:0] {
        // core enable mask, read/write
        ADDR_MASK  = 2'd0,
        // write only, clears counters and store count
        ADDR_CLEAR = 2'd1,
        // accepted store events, read only
        ADDR_COUNT = 2'd2
    } cfg_addr_e;

    // one config access per cycle
    typedef struct packed {
        logic                  we;
        cfg_addr_e             addr;
        logic [CFG_DATA_W-1:0] wdata;
    } cfg_bus_t;

    // output stream beat
    typedef struct packed {
        logic [STREAM_W-1:0] data;
        logic                last;
    } stream_beat_t;

    // readout sequencer states
    typedef enum logic {
        SEQ_IDLE   = 1'b0,
        SEQ_STREAM = 1'b1
    } seq_state_e;

endpackage

`default_nettype wire

// File: rtl/stream_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module stream_sequencer import hdc_pkg::*; #(
    parameter int DIM = 512
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                read_start,
    output logic                                busy,
    output logic                                stream_v,
    output logic [((DIM / STREAM_W) > 1 ? $clog2(DIM / STREAM_W) : 1)-1:0] stream_i,
    output logic                                stream_last,
    output logic                                out_valid
);

    localparam int NWORDS = DIM / STREAM_W;
    localparam int IDX_W  = (NWORDS > 1) ? $clog2(NWORDS) : 1;
    // index of the final beat
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NWORDS - 1);

    seq_state_e state;
    logic       at_last;

    assign at_last = (stream_i == LAST_IDX);

    // read_start only seen in idle, a start while busy is dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= SEQ_IDLE;
            stream_v <= 1'b0;
            stream_i <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (read_start) begin
                        state    <= SEQ_STREAM;
                        stream_v <= 1'b1;
                        stream_i <= '0;
                    end
                end
                SEQ_STREAM: begin
                    // one beat per cycle
                    if (at_last) begin
                        state    <= SEQ_IDLE;
                        stream_v <= 1'b0;
                        stream_i <= '0;
                    end else begin
                        stream_i <= stream_i + 1'b1;
                    end
                end
                default: begin
                    state    <= SEQ_IDLE;
                    stream_v <= 1'b0;
                end
            endcase
        end
    end

    assign busy        = (state == SEQ_STREAM);
    assign stream_last = stream_v && at_last;

    // beat register sits one cycle behind stream_v
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= stream_v;
        end
    end

    // valid flag tracks the FSM exactly
    a_v_matches_state: assert property (
        @(posedge clk) disable iff (rst)
        stream_v == (state == SEQ_STREAM)
    ) else $error("stream_sequencer: stream_v out of step with FSM");

endmodule

`default_nettype wire
